// File: Bender.yml
package:
  name: dcache

export_include_dirs:
  - .

sources:
  - files:
      - dcache_pkg.sv
      - dcache_stage.sv
      - dcache_store.sv
      - dcache_ctrl.sv
      - dcache_top.sv
  - target: test
    files:
      - dcache_assert.sv
      - tb_mem_model.sv
      - tb_dcache.sv

// File: dcache_assert.sv
`timescale 1ns/1ns

module dcache_assert import dcache_pkg::*; (
    input logic     clk,
    input logic     rstn,
    input logic     mem_req,
    input mem_req_t mem_req_data,
    input logic     mem_addr_ok,
    input logic     out_valid,
    input logic     out_ready,
    input logic     req_valid,
    input hit_t     hit
);

    int fail_cnt = 0;

    // request held untouched until the memory takes it
    req_held: assert property (@(posedge clk) disable iff (!rstn)
        mem_req && !mem_addr_ok |=> mem_req && $stable(mem_req_data))
    else begin
        fail_cnt++;
        $error("memory request dropped or changed before addr_ok");
    end

    out_held: assert property (@(posedge clk) disable iff (!rstn)
        out_valid && !out_ready |=> out_valid)
    else begin
        fail_cnt++;
        $error("response valid dropped before out_ready");
    end

    // a line lives in one way only
    hit_single: assert property (@(posedge clk) disable iff (!rstn)
        req_valid |-> hit != 2'b11)
    else begin
        fail_cnt++;
        $error("both ways hit the same lookup");
    end

endmodule

bind dcache_top dcache_assert assert0 (
    .clk(clk), .rstn(rstn),
    .mem_req(mem_req), .mem_req_data(mem_req_data), .mem_addr_ok(mem_addr_ok),
    .out_valid(out_valid), .out_ready(out_ready),
    .req_valid(req_valid), .hit(hit)
);

// File: dcache_ctrl.sv
`timescale 1ns/1ns
`include "dcache_defines.svh"

module dcache_ctrl import dcache_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  dcache_req_t            req,
    output logic                   rsp_valid,
    input  logic                   rsp_ready,
    output dcache_rsp_t            rsp,
    output logic [`DC_INDEX_W-1:0]  index,
    output logic [`DC_TAG_W-1:0]    tag,
    input  hit_t                   hit,
    input  logic                   victim,
    input  line_t                  line,
    output logic                   word_we,
    output logic                   word_way,
    output logic [`DC_OFFSET_W-1:0] word_off,
    output logic [31:0]            word_data,
    output logic [3:0]             word_strb,
    output logic                   refill_we,
    output logic                   refill_way,
    output line_t                  refill_line,
    output logic [`DC_TAG_W-1:0]    refill_tag,
    output logic                   touch,
    output logic                   touch_way,
    output logic                   mem_req,
    output mem_req_t               mem_req_data,
    input  logic                   mem_addr_ok,
    input  logic                   mem_data_ok,
    input  line_t                  mem_rdata,
    input  logic                   mem_bvalid
);

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_miss_read,
        st_miss_read_wait,
        st_write_req,
        st_write_wait,
        st_respond
    } state_t;

    state_t                  state;
    state_t                  next_state;
    logic                    any_hit;
    logic [`DC_OFFSET_W-1:0]  off;

    //////////////////////////////////////////////////
    // address split, request is held by the input stage
    //////////////////////////////////////////////////

    assign off     = req.addr[2 +: `DC_OFFSET_W];
    assign index   = req.addr[2 + `DC_OFFSET_W +: `DC_INDEX_W];
    assign tag     = req.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign any_hit = |hit;

    // store write data, enables come from the FSM
    assign word_way    = hit[1];
    assign word_off    = off;
    assign word_data   = req.wdata;
    assign word_strb   = req.wstrb;
    assign refill_way  = victim;
    assign refill_line = mem_rdata;
    assign refill_tag  = tag;
    assign touch_way   = hit[1];

    // loads fetch the whole line, stores go out as one word
    assign mem_req_data.wr    = req.wr;
    assign mem_req_data.addr  = req.wr ? {req.addr[`DC_ADDR_W-1:2], 2'b00}
                              : {req.addr[`DC_ADDR_W-1:`DC_OFFSET_W+2], {(`DC_OFFSET_W+2){1'b0}}};
    assign mem_req_data.wdata = req.wdata;
    assign mem_req_data.wstrb = req.wstrb;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    //////////////////////////////////////////////////
    // next state and outputs
    //////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        req_ready  = 1'b0;
        rsp_valid  = 1'b0;
        rsp.wr     = req.wr;
        rsp.rdata  = '0;
        word_we    = 1'b0;
        refill_we  = 1'b0;
        touch      = 1'b0;
        mem_req    = 1'b0;
        case (state)
            st_idle: begin
                if (req_valid) begin
                    next_state = st_lookup;
                end
            end
            st_lookup: begin
                if (!req.wr && any_hit) begin
                    // load hit answers right here
                    rsp_valid = 1'b1;
                    rsp.rdata = line[off];
                    if (rsp_ready) begin
                        req_ready  = 1'b1;
                        touch      = 1'b1;
                        next_state = st_idle;
                    end
                end else if (req.wr && any_hit) begin
                    // write-through, update the line then memory
                    word_we    = 1'b1;
                    touch      = 1'b1;
                    next_state = st_write_req;
                end else if (!req.wr) begin
                    next_state = st_miss_read;
                end else begin
                    // no write-allocate
                    next_state = st_write_req;
                end
            end
            st_miss_read: begin
                mem_req = 1'b1;
                if (mem_addr_ok) begin
                    next_state = st_miss_read_wait;
                end
            end
            st_miss_read_wait: begin
                if (mem_data_ok) begin
                    refill_we = 1'b1;
                    // forward the word from the refill data
                    rsp_valid = 1'b1;
                    rsp.rdata = mem_rdata[off];
                    if (rsp_ready) begin
                        req_ready  = 1'b1;
                        next_state = st_idle;
                    end else begin
                        next_state = st_respond;
                    end
                end
            end
            st_write_req: begin
                mem_req = 1'b1;
                if (mem_addr_ok) begin
                    next_state = st_write_wait;
                end
            end
            st_write_wait: begin
                if (mem_bvalid) begin
                    rsp_valid = 1'b1;
                    if (rsp_ready) begin
                        req_ready  = 1'b1;
                        next_state = st_idle;
                    end else begin
                        next_state = st_respond;
                    end
                end
            end
            st_respond: begin
                // refilled line is in the store by now
                rsp_valid = 1'b1;
                if (!req.wr) begin
                    rsp.rdata = line[off];
                end
                if (rsp_ready) begin
                    req_ready  = 1'b1;
                    next_state = st_idle;
                end
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

endmodule

// File: dcache_defines.svh
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

//////////////////////////////////////////////////
// cache geometry
//////////////////////////////////////////////////

// byte address width
`define DC_ADDR_W   32
// 16 sets
`define DC_INDEX_W  4
// word select inside a line
`define DC_OFFSET_W 2
// tag is whatever is left above index, offset and byte bits
`define DC_TAG_W    (`DC_ADDR_W - `DC_INDEX_W - `DC_OFFSET_W - 2)

// line size
`define DC_LINE_W   128
`define DC_WORDS    (`DC_LINE_W / 32)
`define DC_SETS     (1 << `DC_INDEX_W)

`endif

// File: dcache_pkg.sv
`include "dcache_defines.svh"

package dcache_pkg;

    // processor load/store request
    typedef struct packed {
        logic                 wr;
        logic [`DC_ADDR_W-1:0] addr;
        logic [31:0]          wdata;
        logic [3:0]           wstrb;
    } dcache_req_t;

    // one response per request, stores included
    typedef struct packed {
        logic        wr;
        logic [31:0] rdata;
    } dcache_rsp_t;

    // memory port request
    // line address on reads, word address on writes
    typedef struct packed {
        logic                 wr;
        logic [`DC_ADDR_W-1:0] addr;
        logic [31:0]          wdata;
        logic [3:0]           wstrb;
    } mem_req_t;

    // four words, word 0 in the low bits
    typedef logic [`DC_WORDS-1:0][31:0] line_t;

    // one bit per way
    typedef logic [1:0] hit_t;

endpackage

// File: dcache_stage.sv
`timescale 1ns/1ns

module dcache_stage #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rstn,
    input  logic in_valid,
    output logic in_ready,
    input  T     in_data,
    output logic out_valid,
    input  logic out_ready,
    output T     out_data
);

    T           entry [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    // ready while a slot is free, so upstream never sees out_ready
    assign in_ready  = (count != 2'd2);
    assign out_valid = (count != 2'd0);
    assign out_data  = entry[rd_ptr];

    assign push = in_valid & in_ready;
    assign pop  = out_valid & out_ready;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    // payload slots
    always_ff @(posedge clk) begin
        if (push) begin
            entry[wr_ptr] <= in_data;
        end
    end

endmodule

// File: dcache_store.sv
`timescale 1ns/1ns
`include "dcache_defines.svh"

module dcache_store import dcache_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [`DC_INDEX_W-1:0]  index,
    input  logic [`DC_TAG_W-1:0]    tag,
    output hit_t                   hit,
    output logic                   victim,
    output line_t                  line,
    input  logic                   word_we,
    input  logic                   word_way,
    input  logic [`DC_OFFSET_W-1:0] word_off,
    input  logic [31:0]            word_data,
    input  logic [3:0]             word_strb,
    input  logic                   refill_we,
    input  logic                   refill_way,
    input  line_t                  refill_line,
    input  logic [`DC_TAG_W-1:0]    refill_tag,
    input  logic                   touch,
    input  logic                   touch_way
);

    logic [`DC_SETS-1:0]  valid_q [2];
    logic [`DC_TAG_W-1:0] tag_q   [2][`DC_SETS];
    line_t               data_q  [2][`DC_SETS];
    // set bit means way 1 is least recently used
    logic [`DC_SETS-1:0]  lru_q;

    //////////////////////////////////////////////////
    // lookup
    //////////////////////////////////////////////////

    assign hit[0] = valid_q[0][index] && (tag_q[0][index] == tag);
    assign hit[1] = valid_q[1][index] && (tag_q[1][index] == tag);

    // way 0 unless way 1 hits
    assign line = hit[1] ? data_q[1][index] : data_q[0][index];

    // empty ways are filled before anything is evicted
    always_comb begin
        if (!valid_q[0][index]) begin
            victim = 1'b0;
        end else if (!valid_q[1][index]) begin
            victim = 1'b1;
        end else begin
            victim = lru_q[index];
        end
    end

    //////////////////////////////////////////////////
    // updates
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
            lru_q      <= '0;
        end else if (refill_we) begin
            valid_q[refill_way][index] <= 1'b1;
            lru_q[index]               <= ~refill_way;
        end else if (touch) begin
            lru_q[index] <= ~touch_way;
        end
    end

    always_ff @(posedge clk) begin
        if (refill_we) begin
            tag_q[refill_way][index]  <= refill_tag;
            data_q[refill_way][index] <= refill_line;
        end else if (word_we) begin
            // byte lanes under the strobe only
            for (int b = 0; b < 4; b++) begin
                if (word_strb[b]) begin
                    data_q[word_way][index][word_off][b*8 +: 8] <= word_data[b*8 +: 8];
                end
            end
        end
    end

endmodule

// File: dcache_top.sv
`timescale 1ns/1ns
`include "dcache_defines.svh"

module dcache_top import dcache_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        in_valid,
    output logic        in_ready,
    input  dcache_req_t in_req,
    output logic        out_valid,
    input  logic        out_ready,
    output dcache_rsp_t out_rsp,
    output logic        mem_req,
    output mem_req_t    mem_req_data,
    input  logic        mem_addr_ok,
    input  logic        mem_data_ok,
    input  line_t       mem_rdata,
    input  logic        mem_bvalid
);

    // input stage to controller
    logic                   req_valid;
    logic                   req_ready;
    dcache_req_t            req;

    // controller to output stage
    logic                   rsp_valid;
    logic                   rsp_ready;
    dcache_rsp_t            rsp;

    // controller to store
    logic [`DC_INDEX_W-1:0]  index;
    logic [`DC_TAG_W-1:0]    tag;
    hit_t                   hit;
    logic                   victim;
    line_t                  line;
    logic                   word_we;
    logic                   word_way;
    logic [`DC_OFFSET_W-1:0] word_off;
    logic [31:0]            word_data;
    logic [3:0]             word_strb;
    logic                   refill_we;
    logic                   refill_way;
    line_t                  refill_line;
    logic [`DC_TAG_W-1:0]    refill_tag;
    logic                   touch;
    logic                   touch_way;

    dcache_stage #(.T(dcache_req_t)) req_stage (
        .clk(clk), .rstn(rstn),
        .in_valid(in_valid), .in_ready(in_ready), .in_data(in_req),
        .out_valid(req_valid), .out_ready(req_ready), .out_data(req)
    );

    dcache_store store0 (
        .clk(clk), .rstn(rstn),
        .index(index), .tag(tag), .hit(hit), .victim(victim), .line(line),
        .word_we(word_we), .word_way(word_way), .word_off(word_off),
        .word_data(word_data), .word_strb(word_strb),
        .refill_we(refill_we), .refill_way(refill_way),
        .refill_line(refill_line), .refill_tag(refill_tag),
        .touch(touch), .touch_way(touch_way)
    );

    dcache_ctrl ctrl0 (
        .clk(clk), .rstn(rstn),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp(rsp),
        .index(index), .tag(tag), .hit(hit), .victim(victim), .line(line),
        .word_we(word_we), .word_way(word_way), .word_off(word_off),
        .word_data(word_data), .word_strb(word_strb),
        .refill_we(refill_we), .refill_way(refill_way),
        .refill_line(refill_line), .refill_tag(refill_tag),
        .touch(touch), .touch_way(touch_way),
        .mem_req(mem_req), .mem_req_data(mem_req_data), .mem_addr_ok(mem_addr_ok),
        .mem_data_ok(mem_data_ok), .mem_rdata(mem_rdata), .mem_bvalid(mem_bvalid)
    );

    dcache_stage #(.T(dcache_rsp_t)) rsp_stage (
        .clk(clk), .rstn(rstn),
        .in_valid(rsp_valid), .in_ready(rsp_ready), .in_data(rsp),
        .out_valid(out_valid), .out_ready(out_ready), .out_data(out_rsp)
    );

endmodule

// File: sources.f
+incdir+.
dcache_pkg.sv
dcache_stage.sv
dcache_store.sv
dcache_ctrl.sv
dcache_top.sv
dcache_assert.sv
tb_mem_model.sv
tb_dcache.sv

// File: tb_dcache.sv
`timescale 1ns/1ns
`include "dcache_defines.svh"

module tb_dcache import dcache_pkg::*; ();

    typedef struct packed {
        dcache_req_t req;
        logic [7:0]  reads;
    } entry_t;

    localparam int TBL_N = 21;
    // per entry: gaps, stalls, slowest memory accept and reply
    localparam int LIMIT = TBL_N * 64 + 200;

    logic        clk;
    logic        rstn;
    logic        in_valid;
    logic        in_ready;
    dcache_req_t in_req;
    logic        out_valid;
    logic        out_ready = 1'b0;
    dcache_rsp_t out_rsp;
    logic        mem_req;
    mem_req_t    mem_req_data;
    logic        mem_addr_ok;
    logic        mem_data_ok;
    line_t       mem_rdata;
    logic        mem_bvalid;
    logic [2:0]  mem_rnd = 3'd0;
    logic        idle_gap = 1'b0;
    int          rd_count;
    int          wr_count;

    logic [16:0] lfsr = 17'd75070;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    entry_t      tbl [TBL_N];

    // reference model
    logic [31:0]          ref_mem [1024];
    logic                 ref_valid [2][`DC_SETS];
    logic [`DC_TAG_W-1:0] ref_tag [2][`DC_SETS];
    logic                 ref_lru [`DC_SETS];
    int                   model_reads = 0;
    int                   model_writes = 0;
    dcache_rsp_t          exp_rsp [$];
    int                   exp_reads [$];
    int                   exp_writes [$];

    dcache_top dut0 (
        .clk(clk), .rstn(rstn),
        .in_valid(in_valid), .in_ready(in_ready), .in_req(in_req),
        .out_valid(out_valid), .out_ready(out_ready), .out_rsp(out_rsp),
        .mem_req(mem_req), .mem_req_data(mem_req_data), .mem_addr_ok(mem_addr_ok),
        .mem_data_ok(mem_data_ok), .mem_rdata(mem_rdata), .mem_bvalid(mem_bvalid)
    );

    tb_mem_model mem0 (
        .clk(clk), .rstn(rstn),
        .mem_req(mem_req), .mem_req_data(mem_req_data), .mem_addr_ok(mem_addr_ok),
        .mem_data_ok(mem_data_ok), .mem_rdata(mem_rdata), .mem_bvalid(mem_bvalid),
        .rnd(mem_rnd), .rd_count(rd_count), .wr_count(wr_count)
    );

    // x^17 + x^14 + 1, new bit enters at bit 0
    function automatic logic [16:0] lfsr_step(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    function automatic logic [31:0] fill_word(input int i);
        logic [31:0] a;
        a = i * 4;
        return (a * 32'h0001_0001) ^ 32'hc0de_0000;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] want, input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Mismatch at %0t ns: %s, got %h expected %h", $time, what, got, want);
        end
    endtask

    task automatic predict(input dcache_req_t r, input int table_reads);
        logic [9:0]           w;
        logic [3:0]           idx;
        logic [`DC_TAG_W-1:0] tg;
        logic                 hit0;
        logic                 hit1;
        logic                 vic;
        dcache_rsp_t          rsp;
        w    = r.addr[11:2];
        idx  = r.addr[7:4];
        tg   = r.addr[31:8];
        hit0 = ref_valid[0][idx] && (ref_tag[0][idx] == tg);
        hit1 = ref_valid[1][idx] && (ref_tag[1][idx] == tg);
        if (r.wr) begin
            for (int b = 0; b < 4; b++) begin
                if (r.wstrb[b]) begin
                    ref_mem[w][b*8 +: 8] = r.wdata[b*8 +: 8];
                end
            end
            model_writes++;
        end
        if (hit0 || hit1) begin
            // touched way is newest, bit names the other
            ref_lru[idx] = hit0;
        end else if (!r.wr) begin
            vic = !ref_valid[0][idx] ? 1'b0 : (!ref_valid[1][idx] ? 1'b1 : ref_lru[idx]);
            ref_valid[vic][idx] = 1'b1;
            ref_tag[vic][idx]   = tg;
            ref_lru[idx]        = ~vic;
            model_reads++;
        end
        rsp.wr    = r.wr;
        rsp.rdata = r.wr ? 32'h0 : ref_mem[w];
        exp_rsp.push_back(rsp);
        exp_reads.push_back(model_reads);
        exp_writes.push_back(model_writes);
        check(model_reads, table_reads, "table read count");
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // random stalls, gaps and memory delays
    //////////////////////////////////////////////////

    always @(posedge clk) begin : random_gen
        logic [6:0] bits;
        for (int i = 0; i < 7; i++) begin
            lfsr    = lfsr_step(lfsr);
            bits[i] = lfsr[0];
        end
        out_ready <= bits[0] | bits[1];
        idle_gap  <= bits[2] & bits[3];
        mem_rnd   <= bits[6:4];
    end

    always @(posedge clk) begin : monitor
        dcache_rsp_t want;
        if (out_valid && out_ready) begin
            if (exp_rsp.size() == 0) begin
                errors++;
                $display("response at %0t ns with no request waiting for it", $time);
            end else begin
                want = exp_rsp.pop_front();
                check(out_rsp.wr, want.wr, "response kind");
                check(out_rsp.rdata, want.rdata, "load data");
            end
        end
        // memory traffic of a request is done once the controller hands it over
        if (dut0.rsp_valid && dut0.rsp_ready && exp_reads.size() != 0) begin
            check(rd_count, exp_reads.pop_front(), "memory read count");
            check(wr_count, exp_writes.pop_front(), "memory write count");
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles == LIMIT) begin
            $display("timeout after %0d cycles, %0d responses never arrived", cycles,
                     exp_rsp.size());
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // stimulus table and main sequence
    //////////////////////////////////////////////////

    initial begin
        rstn     = 1'b0;
        in_valid = 1'b0;
        in_req   = '0;
        // kind, address, data, strobe, reads after the entry
        tbl[0]  = '{'{1'b0, 32'h034, 32'h0, 4'h0}, 8'd1};
        tbl[1]  = '{'{1'b0, 32'h034, 32'h0, 4'h0}, 8'd1};
        tbl[2]  = '{'{1'b1, 32'h038, 32'haabbccdd, 4'b0101}, 8'd1};
        tbl[3]  = '{'{1'b0, 32'h038, 32'h0, 4'h0}, 8'd1};
        tbl[4]  = '{'{1'b1, 32'h240, 32'h11223344, 4'b1111}, 8'd1};
        tbl[5]  = '{'{1'b0, 32'h240, 32'h0, 4'h0}, 8'd2};
        // three lines on set 3, A is touched before C comes in
        tbl[6]  = '{'{1'b0, 32'h130, 32'h0, 4'h0}, 8'd3};
        tbl[7]  = '{'{1'b0, 32'h030, 32'h0, 4'h0}, 8'd3};
        tbl[8]  = '{'{1'b0, 32'h230, 32'h0, 4'h0}, 8'd4};
        tbl[9]  = '{'{1'b0, 32'h03c, 32'h0, 4'h0}, 8'd4};
        tbl[10] = '{'{1'b0, 32'h134, 32'h0, 4'h0}, 8'd5};
        tbl[11] = '{'{1'b1, 32'h134, 32'h55667788, 4'b1000}, 8'd5};
        tbl[12] = '{'{1'b0, 32'h134, 32'h0, 4'h0}, 8'd5};
        tbl[13] = '{'{1'b1, 32'h500, 32'hdeadbeef, 4'b0011}, 8'd5};
        tbl[14] = '{'{1'b0, 32'h504, 32'h0, 4'h0}, 8'd6};
        tbl[15] = '{'{1'b0, 32'h000, 32'h0, 4'h0}, 8'd7};
        tbl[16] = '{'{1'b1, 32'h00c, 32'h0badf00d, 4'b1111}, 8'd7};
        tbl[17] = '{'{1'b0, 32'h230, 32'h0, 4'h0}, 8'd8};
        tbl[18] = '{'{1'b0, 32'h030, 32'h0, 4'h0}, 8'd9};
        tbl[19] = '{'{1'b1, 32'h248, 32'h01020304, 4'b0110}, 8'd9};
        tbl[20] = '{'{1'b0, 32'h248, 32'h0, 4'h0}, 8'd9};
        for (int i = 0; i < 1024; i++) begin
            ref_mem[i] = fill_word(i);
        end
        for (int s = 0; s < `DC_SETS; s++) begin
            ref_valid[0][s] = 1'b0;
            ref_valid[1][s] = 1'b0;
            ref_lru[s]      = 1'b0;
        end
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);
        for (int n = 0; n < TBL_N; n++) begin
            while (idle_gap) begin
                in_valid <= 1'b0;
                @(posedge clk);
            end
            predict(tbl[n].req, tbl[n].reads);
            in_valid <= 1'b1;
            in_req   <= tbl[n].req;
            @(posedge clk);
            while (!in_ready) @(posedge clk);
        end
        in_valid <= 1'b0;
        while (exp_rsp.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
        for (int i = 0; i < 1024; i++) begin
            check(mem0.mem[i], ref_mem[i], "memory word");
        end
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
                 dut0.assert0.fail_cnt);
        if (errors == 0 && dut0.assert0.fail_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: tb_mem_model.sv
`timescale 1ns/1ns
`include "dcache_defines.svh"

module tb_mem_model import dcache_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic       mem_req,
    input  mem_req_t   mem_req_data,
    output logic       mem_addr_ok,
    output logic       mem_data_ok,
    output line_t      mem_rdata,
    output logic       mem_bvalid,
    input  logic [2:0] rnd,
    output int         rd_count,
    output int         wr_count
);

    // 4 KB of words, indexed by byte address bits 11:2
    logic [31:0] mem [1024];
    logic        busy;
    logic [1:0]  wait_cnt;
    mem_req_t    cur;

    function automatic logic [31:0] fill_word(input int i);
        logic [31:0] a;
        a = i * 4;
        return (a * 32'h0001_0001) ^ 32'hc0de_0000;
    endfunction

    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] = fill_word(i);
        end
    end

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            mem_bvalid  <= 1'b0;
            mem_rdata   <= '0;
            busy        <= 1'b0;
            wait_cnt    <= 2'd0;
            rd_count    <= 0;
            wr_count    <= 0;
        end else begin
            mem_addr_ok <= 1'b0;
            mem_data_ok <= 1'b0;
            mem_bvalid  <= 1'b0;
            if (busy) begin
                if (wait_cnt != 2'd0) begin
                    wait_cnt <= wait_cnt - 2'd1;
                end else begin
                    busy <= 1'b0;
                    if (cur.wr) begin
                        for (int b = 0; b < 4; b++) begin
                            if (cur.wstrb[b]) begin
                                mem[cur.addr[11:2]][b*8 +: 8] = cur.wdata[b*8 +: 8];
                            end
                        end
                        mem_bvalid <= 1'b1;
                    end else begin
                        // line address, low word bits are zero
                        for (int w = 0; w < 4; w++) begin
                            mem_rdata[w] <= mem[cur.addr[11:2] + w];
                        end
                        mem_data_ok <= 1'b1;
                    end
                end
            end else if (mem_req && rnd[0]) begin
                // accept, then answer after 0 to 3 extra cycles
                mem_addr_ok <= 1'b1;
                busy        <= 1'b1;
                cur         <= mem_req_data;
                wait_cnt    <= rnd[2:1];
                if (mem_req_data.wr) begin
                    wr_count <= wr_count + 1;
                end else begin
                    rd_count <= rd_count + 1;
                end
            end
        end
    end

endmodule
